/* logic/link_timing_pkg.sv */
package link_timing_pkg;

    //////////////////////////////////////////////////
    // simulation tick
    //////////////////////////////////////////////////

    // width of the host rate register
    localparam int RATE_W = 16;

    // rate after reset, half period minus one
    // 511 gives a 1024 cycle tick
    localparam logic [RATE_W-1:0] RATE_RESET = 16'd511;

    //////////////////////////////////////////////////
    // spi framing
    //////////////////////////////////////////////////

    // clock cycles per sck half period
    localparam int SPI_CLKDIV = 13;

    // width of the half period counter
    localparam int SPI_DIV_W = $clog2(SPI_CLKDIV);

    // one float per frame
    localparam int SPI_FRAME_BITS = 32;

    // bit counters hold 0..32
    localparam int BITCNT_W = 6;

endpackage

/* logic/spindle_sample_pkg.sv */
package spindle_sample_pkg;

    // host pipe word, 16 bits per write
    typedef logic [15:0] pipe_word_t;

    // ieee-754 single
    // muscle length out, afferent rate in
    typedef logic [31:0] sample_t;

    //////////////////////////////////////////////////
    // waveform store geometry
    //////////////////////////////////////////////////

    localparam int STORE_DEPTH = 64;
    localparam int STORE_AW = 6;

    // float 0.0
    localparam sample_t SAMPLE_ZERO = 32'h0000_0000;

endpackage

/* logic/sim_tick_gen.sv */
`timescale 1ns/1ps

module sim_tick_gen
    import link_timing_pkg::*;
(
    input  logic              ep50trig,
    input  logic              reset_global,
    input  logic              rate_load,
    input  logic [RATE_W-1:0] rate_data,
    output logic              sim_tick
);

    // host set half period, minus one
    logic [RATE_W-1:0] rate_q;

    // counts down from 2*(rate+1)-1
    logic [RATE_W:0] tick_cnt;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            rate_q   <= RATE_RESET;
            tick_cnt <= {RATE_RESET, 1'b1};
            sim_tick <= 1'b0;
        end
        else if (rate_load)
        begin
            // new rate restarts the period
            rate_q   <= rate_data;
            tick_cnt <= {rate_data, 1'b1};
            sim_tick <= 1'b0;
        end
        else if (tick_cnt == '0)
        begin
            tick_cnt <= {rate_q, 1'b1};
            sim_tick <= 1'b1;
        end
        else
        begin
            tick_cnt <= tick_cnt - 1'b1;
            sim_tick <= 1'b0;
        end
    end

endmodule

/* logic/sample_assembler.sv */
`timescale 1ns/1ps

module sample_assembler
    import spindle_sample_pkg::*;
(
    input  logic       ep50trig,
    input  logic       reset_global,
    input  logic       repop,
    input  logic       pipe_write,
    input  pipe_word_t pipe_data,
    output logic       sample_valid,
    output sample_t    sample_word
);

    // low half waits here for its partner
    pipe_word_t low_half;

    // set once the low half is held
    logic have_low;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            have_low     <= 1'b0;
            sample_valid <= 1'b0;
        end
        else if (repop)
        begin
            // new waveform starts on a low half
            have_low     <= 1'b0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= pipe_write && have_low;
            if (pipe_write)
                have_low <= ~have_low;
        end
    end

    // payload path
    always_ff @(posedge ep50trig)
    begin
        if (pipe_write && !have_low)
            low_half <= pipe_data;
        if (pipe_write && have_low)
            sample_word <= {pipe_data, low_half};
    end

endmodule

/* logic/waveform_store.sv */
`timescale 1ns/1ps

module waveform_store
    import spindle_sample_pkg::*;
(
    input  logic    ep50trig,
    input  logic    reset_global,
    input  logic    repop,
    input  logic    sample_valid,
    input  sample_t sample_word,
    input  logic    sample_take,
    output sample_t current_sample,
    output logic    lce_valid
);

    sample_t mem [STORE_DEPTH];

    // fill count doubles as write pointer
    logic [STORE_AW:0]   fill_cnt;
    logic [STORE_AW-1:0] rd_ptr;
    logic [STORE_AW:0]   rd_next;
    logic                store_full;
    logic                wr_en;

    assign store_full = (fill_cnt == (STORE_AW + 1)'(STORE_DEPTH));
    // extra samples past full are dropped
    assign wr_en      = sample_valid && !store_full;
    assign rd_next    = {1'b0, rd_ptr} + 1'b1;
    assign lce_valid  = (fill_cnt != '0);

    //////////////////////////////////////////////////
    // pointers
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            fill_cnt <= '0;
            rd_ptr   <= '0;
        end
        else if (repop)
        begin
            fill_cnt <= '0;
            rd_ptr   <= '0;
        end
        else
        begin
            if (wr_en)
                fill_cnt <= fill_cnt + 1'b1;
            // loop back to the first sample
            if (sample_take)
                rd_ptr <= (rd_next >= fill_cnt) ? '0 : rd_next[STORE_AW-1:0];
        end
    end

    // memory and read register
    always_ff @(posedge ep50trig)
    begin
        if (wr_en)
            mem[fill_cnt[STORE_AW-1:0]] <= sample_word;
        current_sample <= mem[rd_ptr];
    end

    // a write never lands past the last slot
    a_no_write_full: assert property (@(posedge ep50trig) disable iff (reset_global)
        wr_en |-> (fill_cnt < (STORE_AW + 1)'(STORE_DEPTH)));

endmodule

/* logic/spi_sample_sender.sv */
`timescale 1ns/1ps

module spi_sample_sender
    import link_timing_pkg::*;
    import spindle_sample_pkg::*;
(
    input  logic    ep50trig,
    input  logic    reset_global,
    input  logic    sim_tick,
    input  logic    lce_valid,
    input  sample_t current_sample,
    output logic    sample_take,
    output logic    spi_sck,
    output logic    spi_mosi,
    output logic    spi_ssel
);

    sample_t              shift_q;
    logic                 busy;
    logic [SPI_DIV_W-1:0] div_cnt;
    logic [BITCNT_W-1:0]  bit_cnt;
    logic                 start;
    logic                 half_end;

    // ticks during a frame are ignored
    assign start    = sim_tick && !busy && lce_valid;
    assign half_end = busy && (div_cnt == SPI_DIV_W'(SPI_CLKDIV - 1));

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            busy <= 1'b0; sample_take <= 1'b0;
            spi_ssel <= 1'b1; spi_sck <= 1'b0; spi_mosi <= 1'b0;
            div_cnt <= '0; bit_cnt <= '0;
        end
        else
        begin
            sample_take <= start;
            if (start)
            begin
                // msb goes out with ssel
                busy     <= 1'b1;
                spi_ssel <= 1'b0;
                spi_mosi <= current_sample[31];
                div_cnt  <= '0;
                bit_cnt  <= '0;
            end
            else if (busy && !half_end)
                div_cnt <= div_cnt + 1'b1;
            else if (half_end)
            begin
                div_cnt <= '0;
                if (spi_sck)
                begin
                    // falling edge, next bit
                    spi_sck  <= 1'b0;
                    spi_mosi <= shift_q[30];
                    bit_cnt  <= bit_cnt + 1'b1;
                end
                else if (bit_cnt != BITCNT_W'(SPI_FRAME_BITS))
                    spi_sck <= 1'b1;
                else
                begin
                    // one half period after the last fall
                    busy <= 1'b0; spi_ssel <= 1'b1; spi_mosi <= 1'b0;
                end
            end
        end
    end

    // frame payload
    always_ff @(posedge ep50trig)
    begin
        if (start)
            shift_q <= current_sample;
        else if (half_end && spi_sck)
            shift_q <= {shift_q[30:0], 1'b0};
    end

    a_ssel_busy: assert property (@(posedge ep50trig) disable iff (reset_global)
        !spi_ssel |-> busy);

endmodule

/* logic/spi_rate_receiver.sv */
`timescale 1ns/1ps

module spi_rate_receiver
    import link_timing_pkg::*;
    import spindle_sample_pkg::*;
(
    input  logic    ep50trig,
    input  logic    reset_global,
    input  logic    sim_tick,
    input  logic    rx_sck,
    input  logic    rx_mosi,
    input  logic    rx_ssel,
    output logic    rx_ready,
    output sample_t afferent_rate
);

    // two sync flops, third stage for edges
    logic [2:0]          sck_sync, ssel_sync;
    logic [1:0]          mosi_sync;
    logic [BITCNT_W-1:0] bit_cnt;
    logic                overrun;
    sample_t             shift_q, pending;
    logic                sck_rise, ssel_low, frame_ok;

    assign sck_rise = sck_sync[1] & ~sck_sync[2];
    assign ssel_low = ~ssel_sync[1];
    // ssel rising after exactly 32 bits
    assign frame_ok = ssel_sync[1] & ~ssel_sync[2] & !overrun &&
                      (bit_cnt == BITCNT_W'(SPI_FRAME_BITS));

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            sck_sync <= '0; ssel_sync <= '1; mosi_sync <= '0;
            bit_cnt <= '0; overrun <= 1'b0;
            rx_ready <= 1'b0; afferent_rate <= SAMPLE_ZERO;
        end
        else
        begin
            sck_sync  <= {sck_sync[1:0], rx_sck};
            ssel_sync <= {ssel_sync[1:0], rx_ssel};
            mosi_sync <= {mosi_sync[0], rx_mosi};
            if (!ssel_low)
            begin
                bit_cnt <= '0;
                overrun <= 1'b0;
            end
            // long frames flagged, count saturates
            else if (sck_rise && bit_cnt == BITCNT_W'(SPI_FRAME_BITS))
                overrun <= 1'b1;
            else if (sck_rise)
                bit_cnt <= bit_cnt + 1'b1;
            // stays high once a rate has arrived
            if (frame_ok)
                rx_ready <= 1'b1;
            if (sim_tick && rx_ready)
                afferent_rate <= pending;
        end
    end

    always_ff @(posedge ep50trig)
    begin
        if (ssel_low && sck_rise)
            shift_q <= {shift_q[30:0], mosi_sync[1]};
        if (frame_ok)
            pending <= shift_q;
    end

    a_bit_cnt: assert property (@(posedge ep50trig) disable iff (reset_global)
        bit_cnt <= BITCNT_W'(SPI_FRAME_BITS));

endmodule

/* logic/spindle_link_top.sv */
`timescale 1ns/1ps

module spindle_link_top
    import link_timing_pkg::*;
    import spindle_sample_pkg::*;
(
    input  logic              ep50trig,
    input  logic              reset_global,
    input  logic              reset_sim,
    input  logic              rate_load,
    input  logic [RATE_W-1:0] rate_data,
    input  logic              pipe_write,
    input  pipe_word_t        pipe_data,
    input  logic              rx_sck,
    input  logic              rx_mosi,
    input  logic              rx_ssel,
    output logic              spi_sck,
    output logic              spi_mosi,
    output logic              spi_ssel,
    output sample_t           muscle_len,
    output logic              lce_valid,
    output logic              rx_ready,
    output sample_t           afferent_rate
);

    logic    sim_tick;
    logic    sample_valid;
    sample_t sample_word;
    logic    sample_take;

    //////////////////////////////////////////////////
    // tick, muscle length chain, afferent rate
    //////////////////////////////////////////////////

    sim_tick_gen tick0 (.ep50trig, .reset_global, .rate_load, .rate_data, .sim_tick);

    sample_assembler asm0 (.ep50trig, .reset_global, .repop(reset_sim), .pipe_write,
        .pipe_data, .sample_valid, .sample_word);

    waveform_store store0 (.ep50trig, .reset_global, .repop(reset_sim), .sample_valid,
        .sample_word, .sample_take, .current_sample(muscle_len), .lce_valid);

    spi_sample_sender tx0 (.ep50trig, .reset_global, .sim_tick, .lce_valid,
        .current_sample(muscle_len), .sample_take, .spi_sck, .spi_mosi, .spi_ssel);

    spi_rate_receiver rx0 (.ep50trig, .reset_global, .sim_tick, .rx_sck, .rx_mosi,
        .rx_ssel, .rx_ready, .afferent_rate);

endmodule

/* testbench/tb_spindle_link.sv */
`timescale 1ns/1ps

module tb_spindle_link;

    localparam int CLK_PERIOD = 40;
    localparam int FRAME_BITS = 32;
    // ticks the whole run needs
    // slowest tick is 1024 cycles
    localparam int TEST_TICKS = 30;
    localparam int WATCHDOG_NS = TEST_TICKS * 1024 * CLK_PERIOD * 2;

    logic ep50trig, reset_global, reset_sim, rate_load, pipe_write;
    logic rx_sck, rx_mosi, rx_ssel;
    logic [15:0] rate_data, pipe_data;
    logic spi_sck, spi_mosi, spi_ssel, lce_valid, rx_ready;
    logic [31:0] muscle_len, afferent_rate;

    // frame k carries stored_q[k mod N]
    logic [31:0] stored_q [$];
    int period_exp = 0, rate_loads = 0, repop_count = 0, fail_count = 0;
    int frames_started = 0, frames_checked = 0, frame_k = 0, seen_loads = 0;
    int seen_repops = 0, cycle_cnt = 0, last_fall = 0, mon_bits = 0;
    logic [31:0] mon_word, rx_word;
    logic prev_ssel = 1'b1, prev_sck = 1'b0;

    spindle_link_top dut0 (.ep50trig, .reset_global, .reset_sim, .rate_load, .rate_data,
        .pipe_write, .pipe_data, .rx_sck, .rx_mosi, .rx_ssel, .spi_sck, .spi_mosi, .spi_ssel,
        .muscle_len, .lce_valid, .rx_ready, .afferent_rate);

    initial
    begin
        ep50trig = 1'b0;
        forever #(CLK_PERIOD / 2) ep50trig = ~ep50trig;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // lands 2 ns after a rising edge
    task automatic step_cycles(input int n);
        repeat (n) @(posedge ep50trig);
        #2;
    endtask

    task automatic abort_run;
        $display("** FAIL **");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            fail_count++;
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // low pipe word first then high word
    function automatic logic [31:0] expect_sample(input logic [15:0] lo, input logic [15:0] hi);
        return {hi, lo};
    endfunction

    task automatic load_rate(input logic [15:0] r);
        rate_data = r;
        rate_load = 1'b1;
        // ssel falls once per tick of 2*(rate+1) cycles
        period_exp = 2 * (int'(r) + 1);
        rate_loads++;
        step_cycles(1);
        rate_load = 1'b0;
    endtask

    task automatic write_samples(input int n);
        logic [31:0] word;
        int i;
        for (i = 0; i < n; i++)
        begin
            word = $urandom();
            pipe_write = 1'b1;
            pipe_data = word[15:0];
            step_cycles(1);
            pipe_data = word[31:16];
            step_cycles(1);
            stored_q.push_back(expect_sample(word[15:0], word[31:16]));
        end
        pipe_write = 1'b0;
    endtask

    // slow spi master on the rx pins sending msb first
    task automatic send_rx_frame(input logic [31:0] word, input int nbits);
        int i;
        rx_ssel = 1'b0;
        for (i = nbits - 1; i >= 0; i--)
        begin
            rx_mosi = word[i];
            step_cycles(4);
            rx_sck = 1'b1;
            step_cycles(4);
            rx_sck = 1'b0;
        end
        step_cycles(4);
        rx_ssel = 1'b1;
        step_cycles(4);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_checked + n;
        while (frames_checked < target)
            @(posedge ep50trig);
        #2;
    endtask

    // ssel falls one cycle after a tick
    task automatic wait_starts(input int n);
        int target;
        target = frames_started + n;
        while (frames_started < target)
            @(posedge ep50trig);
        #2;
    endtask

    //////////////////////////////////////////////////
    // frame monitor sampled mid cycle
    //////////////////////////////////////////////////

    always @(negedge ep50trig)
    begin
        cycle_cnt++;
        if (!reset_global && prev_ssel && !spi_ssel)
        begin
            check_value(32'(stored_q.size() != 0), 1, "frame sent from an empty store");
            if (seen_repops != repop_count)
            begin
                frame_k = 0;
                seen_repops = repop_count;
            end
            // store output still holds the sample now being framed
            check_value(muscle_len, stored_q[frame_k % stored_q.size()],
                        "muscle_len at frame start");
            // first frame after a rate load has no reference edge
            if (seen_loads != rate_loads)
                seen_loads = rate_loads;
            else
                check_value(cycle_cnt - last_fall, period_exp, "cycles between ssel falls");
            last_fall = cycle_cnt;
            mon_bits = 0;
            frames_started++;
        end
        // mosi is stable across the sck rise
        if (!reset_global && !spi_ssel && spi_sck && !prev_sck)
        begin
            mon_word = {mon_word[30:0], spi_mosi};
            mon_bits++;
        end
        if (!reset_global && !prev_ssel && spi_ssel)
        begin
            check_value(mon_bits, FRAME_BITS, "bits in frame");
            check_value(mon_word, stored_q[frame_k % stored_q.size()], "frame word");
            frame_k++;
            frames_checked++;
        end
        prev_ssel = spi_ssel;
        prev_sck = spi_sck;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the tests did not finish in time");
        abort_run();
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial
    begin
        void'($urandom(32'h8fd4));
        reset_global = 1'b1;
        reset_sim = 1'b0;
        rate_load = 1'b0;
        rate_data = '0;
        pipe_write = 1'b0;
        pipe_data = '0;
        rx_sck = 1'b0;
        rx_mosi = 1'b0;
        rx_ssel = 1'b1;
        step_cycles(10);
        reset_global = 1'b0;

        // reset levels then a full tick with an empty store
        step_cycles(1);
        check_value(32'({spi_ssel, spi_sck, spi_mosi, lce_valid, rx_ready}), 32'b10000,
                    "ssel sck mosi lce_valid rx_ready after reset");
        check_value(afferent_rate, 32'h0, "afferent rate after reset");
        step_cycles(1100);
        check_value(frames_started, 0, "frames while lce_valid is low");

        // replay of 5 samples at a loaded rate with the period checked per frame
        load_rate(16'(450 + $urandom_range(0, 60)));
        write_samples(5);
        wait_frames(12);

        // good 32-bit rate frame then a short frame that is dropped
        rx_word = $urandom();
        send_rx_frame(rx_word, 32);
        check_value(32'(rx_ready), 1, "rx_ready after a full frame");
        wait_starts(1);
        check_value(afferent_rate, rx_word, "afferent rate after tick");
        send_rx_frame($urandom(), 20);
        wait_starts(1);
        check_value(afferent_rate, rx_word, "afferent rate after a 20-bit frame");

        // repopulate between frames with a new, shorter waveform
        wait_frames(1);
        reset_sim = 1'b1;
        step_cycles(1);
        reset_sim = 1'b0;
        check_value(32'(lce_valid), 0, "lce_valid after reset_sim");
        stored_q.delete();
        repop_count++;
        load_rate(16'(450 + $urandom_range(0, 60)));
        write_samples(3);
        wait_frames(7);

        if (fail_count == 0)
        begin
            $display("** PASS **");
            $finish;
        end
        else
            abort_run();
    end

endmodule

/* spindle_link.f */
logic/link_timing_pkg.sv
logic/spindle_sample_pkg.sv
logic/sim_tick_gen.sv
logic/sample_assembler.sv
logic/waveform_store.sv
logic/spi_sample_sender.sv
logic/spi_rate_receiver.sv
logic/spindle_link_top.sv
testbench/tb_spindle_link.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_spindle_link
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert
FILELIST  ?= spindle_link.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
